// File: include/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Integer data path width.
`define XLEN 32

// Architectural register file.
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

// File: design/exec_pkg.sv
`include "exec_params.svh"

package exec_pkg;

  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_LUI, OP_JAL, OP_BEQ, OP_BNE, OP_BLT,
    OP_BLTU, OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_NOP
  } op_t;

  // One decoded instruction as it leaves the issuer.
  typedef struct packed {
    logic                   valid;
    op_t                    op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic                   use_imm;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       pc;
  } micro_op_t;

  typedef struct packed {
    micro_op_t lane1;
    micro_op_t lane0;
  } issue_bundle_t;

  typedef struct packed {
    micro_op_t        uop;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
  } operand_t;

  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       wdata;
    logic [`XLEN-1:0]       pc;
  } retire_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic             start; // Single cycle pulse.
    op_t              op;
    logic [`XLEN-1:0] dividend;
    logic [`XLEN-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    logic             ready;
    logic [`XLEN-1:0] result;
  } div_resp_t;

endpackage

// File: design/register_file.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module register_file import exec_pkg::*; (
  input  logic                         clock,
  input  logic [3:0][`REG_ADDR_W-1:0]  raddr,
  output logic [3:0][`XLEN-1:0]        rdata,
  input  retire_t                      retire0,
  input  retire_t                      retire1
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // Lane 1 is younger, so its write lands last.
  always_ff @(posedge clock) begin
    if (retire0.valid && retire0.rd != '0) begin
      regs[retire0.rd] <= retire0.wdata;
    end
    if (retire1.valid && retire1.rd != '0) begin
      regs[retire1.rd] <= retire1.wdata;
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (raddr[i] == '0) begin
        rdata[i] = '0; // x0 is hardwired.
      end else if (retire1.valid && retire1.rd == raddr[i]) begin
        rdata[i] = retire1.wdata;
      end else if (retire0.valid && retire0.rd == raddr[i]) begin
        rdata[i] = retire0.wdata;
      end else begin
        rdata[i] = regs[raddr[i]];
      end
    end
  end

endmodule

// File: design/int_alu.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module int_alu import exec_pkg::*; (
  input  op_t              op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] result
);

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (op)
      OP_ADD:  result = a + b;
      OP_SUB:  result = a - b;
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_XOR:  result = a ^ b;
      OP_SLL:  result = a << shamt;
      OP_SRL:  result = a >> shamt;
      OP_SRA:  result = $signed(a) >>> shamt;
      OP_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      OP_SLTU: result = {{(`XLEN-1){1'b0}}, a < b};
      OP_LUI:  result = b; // The immediate arrives already shifted.
      default: result = '0;
    endcase
  end

endmodule

// File: design/branch_unit.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module branch_unit import exec_pkg::*; (
  input  operand_t         uop,
  output logic             taken,
  output logic [`XLEN-1:0] target,
  output logic [`XLEN-1:0] link
);

  localparam logic [`XLEN-1:0] INSN_BYTES = 4;

  always_comb begin
    case (uop.uop.op)
      OP_JAL:  taken = 1'b1;
      OP_BEQ:  taken = uop.rdata1 == uop.rdata2;
      OP_BNE:  taken = uop.rdata1 != uop.rdata2;
      OP_BLT:  taken = $signed(uop.rdata1) < $signed(uop.rdata2);
      OP_BLTU: taken = uop.rdata1 < uop.rdata2;
      default: taken = 1'b0;
    endcase
  end

  // Both jal and the conditional branches are pc relative.
  assign target = uop.uop.pc + uop.uop.imm;
  assign link   = uop.uop.pc + INSN_BYTES;

endmodule

// File: design/serial_divider.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module serial_divider import exec_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  div_req_t  req,
  output div_resp_t resp
);

  localparam int CNT_W = $clog2(`XLEN + 1);

  logic             busy;
  logic             done;
  logic [CNT_W-1:0] count;
  logic [`XLEN-1:0] rem_q;
  logic [`XLEN-1:0] quot_q;
  logic [`XLEN-1:0] dsor_q;
  logic             want_rem;
  logic             neg_quot;
  logic             neg_rem;
  logic             is_signed;
  logic [`XLEN-1:0] dividend_abs;
  logic [`XLEN-1:0] divisor_abs;
  logic [`XLEN:0]   trial;

  assign is_signed = (req.op == OP_DIV) || (req.op == OP_REM);
  assign dividend_abs = (is_signed && req.dividend[`XLEN-1]) ? -req.dividend : req.dividend;
  assign divisor_abs  = (is_signed && req.divisor[`XLEN-1]) ? -req.divisor : req.divisor;

  // Shift in the next dividend bit and try to subtract.
  assign trial = {rem_q, quot_q[`XLEN-1]} - {1'b0, dsor_q};

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (req.start) begin
        busy  <= 1'b1;
        count <= CNT_W'(`XLEN);
      end else if (busy) begin
        count <= count - 1'b1;
        if (count == CNT_W'(1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req.start) begin
      rem_q    <= '0;
      quot_q   <= dividend_abs;
      dsor_q   <= divisor_abs;
      want_rem <= (req.op == OP_REM) || (req.op == OP_REMU);
      // A zero divisor keeps the all ones quotient unsigned.
      neg_quot <= is_signed && (req.dividend[`XLEN-1] ^ req.divisor[`XLEN-1]) &&
                  (req.divisor != '0);
      neg_rem  <= is_signed && req.dividend[`XLEN-1];
    end else if (busy) begin
      if (!trial[`XLEN]) begin
        rem_q  <= trial[`XLEN-1:0];
        quot_q <= {quot_q[`XLEN-2:0], 1'b1};
      end else begin
        rem_q  <= {rem_q[`XLEN-2:0], quot_q[`XLEN-1]};
        quot_q <= {quot_q[`XLEN-2:0], 1'b0};
      end
    end
  end

  assign resp.ready  = done;
  assign resp.result = want_rem ? (neg_rem ? -rem_q : rem_q) : (neg_quot ? -quot_q : quot_q);

endmodule

// File: design/operand_stage.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module operand_stage import exec_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        issue_valid,
  input  issue_bundle_t               issue,
  input  logic                        stall,
  input  logic                        flush,
  output logic [3:0][`REG_ADDR_W-1:0] rf_raddr,
  input  logic [3:0][`XLEN-1:0]       rf_rdata,
  input  retire_t [1:0]               exec_fwd,
  input  retire_t [1:0]               retire_fwd,
  output operand_t [1:0]              operands
);

  operand_t [1:0] next_ops;
  operand_t [1:0] op_q;
  retire_t [3:0]  srcs;

  // Oldest source sits at index 0 so that later matches override it.
  function automatic logic [`XLEN-1:0] pick(input logic [`REG_ADDR_W-1:0] addr,
                                            input logic [`XLEN-1:0] rf_value,
                                            input retire_t [3:0] fwd);
    logic [`XLEN-1:0] value;
    value = rf_value;
    for (int i = 0; i < 4; i++) begin
      if (fwd[i].valid && fwd[i].rd == addr && addr != '0) begin
        value = fwd[i].wdata;
      end
    end
    return value;
  endfunction

  assign srcs = {exec_fwd[1], exec_fwd[0], retire_fwd[1], retire_fwd[0]};
  assign rf_raddr = {issue.lane1.rs2, issue.lane1.rs1, issue.lane0.rs2, issue.lane0.rs1};

  always_comb begin
    next_ops[0].uop    = issue.lane0;
    next_ops[0].rdata1 = pick(issue.lane0.rs1, rf_rdata[0], srcs);
    next_ops[0].rdata2 = pick(issue.lane0.rs2, rf_rdata[1], srcs);
    next_ops[1].uop    = issue.lane1;
    next_ops[1].rdata1 = pick(issue.lane1.rs1, rf_rdata[2], srcs);
    next_ops[1].rdata2 = pick(issue.lane1.rs2, rf_rdata[3], srcs);
    if (!issue_valid || flush) begin
      next_ops[0].uop.valid = 1'b0; // Bubble.
      next_ops[1].uop.valid = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      op_q[0].uop.valid <= 1'b0;
      op_q[1].uop.valid <= 1'b0;
    end else if (!stall) begin
      op_q <= next_ops;
    end
  end

  assign operands = op_q;

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module execute_stage import exec_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  operand_t [1:0] operands,
  input  div_resp_t      div_resp,
  output div_req_t       div_req,
  output logic           stall,
  output logic           flush,
  output retire_t [1:0]  exec_fwd,
  output retire_t        retire0,
  output retire_t        retire1,
  output redirect_t      redirect
);

  typedef struct packed {
    retire_t   retire0;
    retire_t   retire1;
    redirect_t redirect;
  } exec_reg_t;

  exec_reg_t        r, rin;
  exec_reg_t        v;
  logic             div_busy; // Divide issued, result still pending.
  logic             is_div;
  logic             is_ctrl;
  logic [`XLEN-1:0] alu0_b;
  logic [`XLEN-1:0] alu1_b;
  logic [`XLEN-1:0] alu0_result;
  logic [`XLEN-1:0] alu1_result;
  logic             taken;
  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] link;

  assign alu0_b = operands[0].uop.use_imm ? operands[0].uop.imm : operands[0].rdata2;
  assign alu1_b = operands[1].uop.use_imm ? operands[1].uop.imm : operands[1].rdata2;

  int_alu alu0 (.op(operands[0].uop.op), .a(operands[0].rdata1), .b(alu0_b),
                .result(alu0_result));
  int_alu alu1 (.op(operands[1].uop.op), .a(operands[1].rdata1), .b(alu1_b),
                .result(alu1_result));

  branch_unit bcu0 (.uop(operands[0]), .taken(taken), .target(target), .link(link));

  always_comb begin
    v = r;

    v.retire0.valid = operands[0].uop.valid && (operands[0].uop.op != OP_NOP);
    v.retire0.rd    = operands[0].uop.rd;
    v.retire0.pc    = operands[0].uop.pc;
    v.retire0.wdata = alu0_result;

    v.retire1.valid = operands[1].uop.valid && (operands[1].uop.op != OP_NOP);
    v.retire1.rd    = operands[1].uop.rd;
    v.retire1.pc    = operands[1].uop.pc;
    v.retire1.wdata = alu1_result;

    is_div  = operands[0].uop.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    is_ctrl = operands[0].uop.op inside {OP_JAL, OP_BEQ, OP_BNE, OP_BLT, OP_BLTU};

    div_req.start    = v.retire0.valid & is_div & ~div_busy;
    div_req.op       = operands[0].uop.op;
    div_req.dividend = operands[0].rdata1;
    div_req.divisor  = operands[0].rdata2;

    if (is_ctrl) begin
      v.retire0.wdata = link; // Branches report the link value too.
    end else if (is_div) begin
      v.retire0.wdata = div_resp.result;
    end

    v.redirect.valid = v.retire0.valid & is_ctrl & taken;
    if (v.redirect.valid) begin
      v.redirect.target = target;
    end

    stall = v.retire0.valid & is_div & ~div_resp.ready;
    if (stall) begin
      v.retire0.valid = 1'b0;
      v.retire1.valid = 1'b0;
    end

    // Lane 1 follows the branch in program order.
    if (v.redirect.valid) begin
      v.retire1.valid = 1'b0;
    end

    flush = v.redirect.valid;

    exec_fwd[0] = v.retire0;
    exec_fwd[1] = v.retire1;

    rin = v;
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      r.retire0.valid  <= 1'b0;
      r.retire1.valid  <= 1'b0;
      r.redirect.valid <= 1'b0;
      div_busy         <= 1'b0;
    end else begin
      r <= rin;
      if (div_resp.ready) begin
        div_busy <= 1'b0;
      end else if (div_req.start) begin
        div_busy <= 1'b1;
      end
    end
  end

  assign retire0  = r.retire0;
  assign retire1  = r.retire1;
  assign redirect = r.redirect;

endmodule

// File: design/exec_core.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_core import exec_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          issue_valid,
  input  issue_bundle_t issue,
  output logic          issue_ready,
  output retire_t       retire0,
  output retire_t       retire1,
  output redirect_t     redirect
);

  operand_t [1:0]              operands;
  retire_t [1:0]               exec_fwd;
  logic                        stall;
  logic                        flush;
  logic [3:0][`REG_ADDR_W-1:0] rf_raddr;
  logic [3:0][`XLEN-1:0]       rf_rdata;
  div_req_t                    div_req;
  div_resp_t                   div_resp;

  assign issue_ready = ~stall;

  operand_stage operand_stage0 (
    .clock(clock), .reset(reset), .issue_valid(issue_valid), .issue(issue),
    .stall(stall), .flush(flush), .rf_raddr(rf_raddr), .rf_rdata(rf_rdata),
    .exec_fwd(exec_fwd), .retire_fwd({retire1, retire0}), .operands(operands)
  );

  execute_stage execute_stage0 (
    .clock(clock), .reset(reset), .operands(operands), .div_resp(div_resp),
    .div_req(div_req), .stall(stall), .flush(flush), .exec_fwd(exec_fwd),
    .retire0(retire0), .retire1(retire1), .redirect(redirect)
  );

  register_file register_file0 (
    .clock(clock), .raddr(rf_raddr), .rdata(rf_rdata),
    .retire0(retire0), .retire1(retire1)
  );

  serial_divider serial_divider0 (
    .clock(clock), .reset(reset), .req(div_req), .resp(div_resp)
  );

endmodule

// File: sim/exec_core_tb.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_core_tb import exec_pkg::*; ();

  localparam int MEM_WORDS    = 1024;
  localparam int BUNDLE_WORDS = 16; // Eight words per lane.
  localparam int EXPECT_WORDS = 4;
  localparam int RESET_CYCLES = 10;
  localparam int DRAIN_CYCLES = 10;

  logic          clock;
  logic          reset;
  logic          issue_valid;
  issue_bundle_t issue;
  logic          issue_ready;
  retire_t       retire0;
  retire_t       retire1;
  redirect_t     redirect;

  logic [`XLEN-1:0] test_mem [MEM_WORDS];
  int               bundle_count;
  int               expect_count;
  int               expect_base;
  int               next_expect;
  int               checks;
  int               errors;
  int               low_ready_cycles;

  exec_core dut0 (
    .clock(clock), .reset(reset), .issue_valid(issue_valid), .issue(issue),
    .issue_ready(issue_ready), .retire0(retire0), .retire1(retire1), .redirect(redirect)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  function automatic micro_op_t uop_at(input int base);
    micro_op_t u;
    u.valid   = test_mem[base][0];
    u.op      = op_t'(test_mem[base + 1][4:0]);
    u.rd      = test_mem[base + 2][`REG_ADDR_W-1:0];
    u.rs1     = test_mem[base + 3][`REG_ADDR_W-1:0];
    u.rs2     = test_mem[base + 4][`REG_ADDR_W-1:0];
    u.use_imm = test_mem[base + 5][0];
    u.imm     = test_mem[base + 6];
    u.pc      = test_mem[base + 7];
    return u;
  endfunction

  // Every divide holds lane 0 for XLEN+1 cycles with issue_ready low.
  function automatic int count_divides();
    int        n;
    micro_op_t u;
    n = 0;
    for (int i = 0; i < bundle_count; i++) begin
      u = uop_at(2 + i * BUNDLE_WORDS);
      if (u.valid && u.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic check_record(input logic is_redirect, input logic [`REG_ADDR_W-1:0] rd,
                              input logic [`XLEN-1:0] value, input logic [`XLEN-1:0] pc);
    int base;
    base = expect_base + next_expect * EXPECT_WORDS;
    checks++;
    if (next_expect >= expect_count) begin
      errors++;
      $display("** Error at %0t: extra record kind %0d rd %0d value %h pc %h",
               $time, is_redirect, rd, value, pc);
    end else begin
      if (test_mem[base][0] != is_redirect || test_mem[base + 1][`REG_ADDR_W-1:0] != rd ||
          test_mem[base + 2] != value || test_mem[base + 3] != pc) begin
        errors++;
        $write("** Error at %0t: record %0d is kind %0d rd %0d value %h pc %h,",
               $time, next_expect, is_redirect, rd, value, pc);
        $display(" expected kind %0d rd %0d value %h pc %h", test_mem[base][0],
                 test_mem[base + 1], test_mem[base + 2], test_mem[base + 3]);
      end
      next_expect++;
    end
  endtask

  task automatic apply_reset();
    reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    checks++;
    if (retire0.valid !== 1'b0 || retire1.valid !== 1'b0 || redirect.valid !== 1'b0 ||
        issue_ready !== 1'b1) begin
      errors++;
      $display("** Error at %0t: outputs not idle in reset, retire %b %b redirect %b ready %b",
               $time, retire0.valid, retire1.valid, redirect.valid, issue_ready);
    end
    reset = 1'b1;
  endtask

  // Lane 0, lane 1, then the redirect, which is the program order of one cycle.
  task automatic monitor_outputs();
    forever begin
      @(negedge clock);
      if (retire0.valid) begin
        check_record(1'b0, retire0.rd, retire0.wdata, retire0.pc);
      end
      if (retire1.valid) begin
        check_record(1'b0, retire1.rd, retire1.wdata, retire1.pc);
      end
      if (redirect.valid) begin
        check_record(1'b1, '0, redirect.target, '0);
      end
      if (!issue_ready) begin
        low_ready_cycles++;
      end
    end
  endtask

  task automatic issue_bundles();
    int   idx;
    logic ready_seen;
    idx = 0;
    while (idx < bundle_count) begin
      issue_valid = 1'b1;
      issue.lane0 = uop_at(2 + idx * BUNDLE_WORDS);
      issue.lane1 = uop_at(2 + idx * BUNDLE_WORDS + BUNDLE_WORDS / 2);
      ready_seen  = issue_ready; // Stable until the next rising edge.
      @(negedge clock);
      if (ready_seen) begin
        idx++;
      end
    end
    issue_valid = 1'b0;
    issue       = '0;
  endtask

  initial begin
    reset            = 1'b0;
    issue_valid      = 1'b0;
    issue            = '0;
    next_expect      = 0;
    checks           = 0;
    errors           = 0;
    low_ready_cycles = 0;
    $readmemh("sim/exec_tests.txt", test_mem);
    bundle_count = int'(test_mem[0]);
    expect_count = int'(test_mem[1]);
    expect_base  = 2 + bundle_count * BUNDLE_WORDS;
    if (bundle_count <= 0 || expect_count <= 0 ||
        expect_base + expect_count * EXPECT_WORDS > MEM_WORDS) begin
      errors++;
      $display("Test data in sim/exec_tests.txt is missing or malformed.");
    end else begin
      apply_reset();
      fork
        monitor_outputs();
      join_none
      issue_bundles();
      while (next_expect < expect_count) begin
        @(negedge clock);
      end
      repeat (DRAIN_CYCLES) @(negedge clock);
      checks++;
      if (low_ready_cycles != count_divides() * (`XLEN + 1)) begin
        errors++;
        $display("** Error at %0t: issue_ready low for %0d cycles, expected %0d",
                 $time, low_ready_cycles, count_divides() * (`XLEN + 1));
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    @(posedge clock);
    repeat (bundle_count * (`XLEN + 4) + 100) @(posedge clock);
    $display("Run timed out with %0d of %0d records seen.", next_expect, expect_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sim/exec_tests.txt
// First line: bundle count, expected record count.
// Bundle: per lane valid op rd rs1 rs2 use_imm imm pc, lane 0 then lane 1.
// Expected: kind (0 retire, 1 redirect) rd value pc, in retire order.
14 1f
1 00 01 00 00 1 00000005 00000100  1 0a 02 00 00 1 12345000 00000104
1 01 03 02 01 0 00000000 00000108  1 04 04 01 00 1 000000ff 0000010c
1 05 05 01 00 1 00000004 00000110  1 08 06 04 03 0 00000000 00000114
1 01 07 00 01 0 00000000 00000118  1 03 08 05 06 0 00000000 0000011c
1 07 09 07 00 1 00000002 00000120  1 06 0a 07 00 1 0000001c 00000124
1 09 0b 01 07 0 00000000 00000128  1 02 0c 09 08 0 00000000 0000012c
1 0c 00 01 07 0 00000040 00000130  1 00 0d 01 00 1 00000001 00000134
1 0e 00 07 01 0 00000100 00000138  1 00 0e 00 00 1 00000077 0000013c
1 00 0f 00 00 1 00000099 00000140  1 00 10 00 00 1 00000088 00000144
1 0b 11 00 00 0 00000020 00000238  1 00 12 00 00 1 00000001 0000023c
1 00 13 00 00 1 00000055 00000240  0 14 00 00 00 0 00000000 00000244
1 10 14 07 01 0 00000000 00000258  1 00 15 01 00 1 00000002 0000025c
1 11 16 14 01 0 00000000 00000260  0 14 00 00 00 0 00000000 00000264
1 10 17 01 00 0 00000000 00000268  0 14 00 00 00 0 00000000 0000026c
1 12 18 07 00 0 00000000 00000270  0 14 00 00 00 0 00000000 00000274
1 0a 19 00 00 1 80000000 00000278  1 01 1a 00 00 1 00000001 0000027c
1 10 1b 19 1a 0 00000000 00000280  0 14 00 00 00 0 00000000 00000284
1 12 1c 19 1a 0 00000000 00000288  1 00 1d 1b 00 1 00000000 0000028c
1 13 1e 07 0d 0 00000000 00000290  1 04 1f 01 00 1 00000003 00000294
1 00 0f 1e 16 0 00000000 00000298  0 14 00 00 00 0 00000000 0000029c
0 01 00000005 00000100
0 02 12345000 00000104
0 03 12344ffb 00000108
0 04 000000fa 0000010c
0 05 00000050 00000110
0 06 00000001 00000114
0 07 fffffffb 00000118
0 08 00000051 0000011c
0 09 fffffffe 00000120
0 0a 0000000f 00000124
0 0b 00000001 00000128
0 0c 00000050 0000012c
0 00 00000134 00000130
0 0d 00000006 00000134
0 00 0000013c 00000138
1 00 00000238 00000000
0 11 0000023c 00000238
1 00 00000258 00000000
0 14 ffffffff 00000258
0 15 00000007 0000025c
0 16 33333333 00000260
0 17 ffffffff 00000268
0 18 fffffffb 00000270
0 19 80000000 00000278
0 1a ffffffff 0000027c
0 1b 80000000 00000280
0 1c 00000000 00000288
0 1d 80000000 0000028c
0 1e 00000005 00000290
0 1f 00000006 00000294
0 0f 33333338 00000298

// File: src.f
+incdir+include
design/exec_pkg.sv
design/register_file.sv
design/int_alu.sv
design/branch_unit.sv
design/serial_divider.sv
design/operand_stage.sv
design/execute_stage.sv
design/exec_core.sv
sim/exec_core_tb.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := exec_core_tb
FILE_LIST  := src.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
